/* logic/eeprom_settings.svh */
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// memory geometry, 24C16 style
`define EE_ADDR_W     11
`define EE_DATA_W     8

// queue entries, power of two
`define EE_CMD_DEPTH  4

// CLK cycles per scl half period, 2 or more
`define EE_SCL_HALF   4

`define EE_DEV_CODE   4'b1010   // device type code in control byte

`endif

/* logic/eeprom_pkg.sv */
`include "eeprom_settings.svh"

package eeprom_pkg;

    // one queued host request
    typedef struct packed {
        logic                  rd;     // 1 = read, 0 = write
        logic [`EE_ADDR_W-1:0] addr;
        logic [`EE_DATA_W-1:0] data;
    } eeprom_cmd_t;

    typedef enum logic [3:0] {
        PH_IDLE,
        PH_START,
        PH_CTRL_WR,
        PH_ADDR,
        PH_DATA_WR,
        PH_RSTART,
        PH_CTRL_RD,
        PH_DATA_RD,
        PH_MNACK,
        PH_STOP
    } eeprom_phase_t;

    localparam int EE_CMD_W  = $bits(eeprom_cmd_t);
    localparam int EE_BANK_W = `EE_ADDR_W - `EE_DATA_W;   // upper bits in control byte

endpackage

/* logic/eeprom_host_port.sv */
`timescale 1ns/10ps
`include "eeprom_settings.svh"

module eeprom_host_port (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  logic [`EE_ADDR_W-1:0]   addr,
    input  logic [`EE_DATA_W-1:0]   wdata,
    input  logic                    done,
    output logic                    push,
    output eeprom_pkg::eeprom_cmd_t cmd,
    output logic                    busy,
    output logic                    idle
);

    localparam int DEPTH = `EE_CMD_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             accept;
    logic [CNT_W-1:0] pending;
    logic [CNT_W-1:0] pending_nxt;

    assign accept = (wr | rd) & ~busy;   // strobes during busy are dropped

    // counted from the accepting edge, so busy rises together with push
    always_comb
    begin
        pending_nxt = pending;
        if (accept && !done)
            pending_nxt = pending + 1'b1;
        else if (!accept && done)
            pending_nxt = pending - 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            push    <= 1'b0;
            pending <= '0;
            busy    <= 1'b0;
            idle    <= 1'b1;
        end
        else
        begin
            push    <= accept;
            pending <= pending_nxt;
            busy    <= (pending_nxt == CNT_W'(DEPTH));
            idle    <= (pending_nxt == '0);
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd.rd   <= rd & ~wr;   // write wins
            cmd.addr <= addr;
            cmd.data <= wdata;
        end
    end

endmodule

/* logic/eeprom_cmd_fifo.sv */
`timescale 1ns/10ps

module eeprom_cmd_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    push,
    input  eeprom_pkg::eeprom_cmd_t din,
    input  logic                    pop,
    output eeprom_pkg::eeprom_cmd_t dout,
    output logic                    empty
);
    import eeprom_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    logic [EE_CMD_W-1:0] mem [DEPTH];

    // extra msb is the wrap bit
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign dout  = eeprom_cmd_t'(mem[rd_ptr[PTR_W-1:0]]);   // head, no read latency

    always_ff @(posedge CLK)
    begin
        if (push)
            mem[wr_ptr[PTR_W-1:0]] <= din;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* logic/eeprom_serial_engine.sv */
`timescale 1ns/10ps
`include "eeprom_settings.svh"

module eeprom_serial_engine (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    empty,
    input  eeprom_pkg::eeprom_cmd_t cmd_in,
    input  logic                    sda_in,
    output logic                    pop,
    output logic                    scl,
    output logic                    sda_out,
    output logic                    sda_oe,
    output logic                    done,
    output logic                    nack,
    output logic [`EE_DATA_W-1:0]   rd_data
);
    import eeprom_pkg::*;

    localparam int HALF  = `EE_SCL_HALF;
    localparam int CNT_W = $clog2(2 * HALF);

    // slot positions; outputs are registered so they show one cycle later
    localparam logic [CNT_W-1:0] DRV  = CNT_W'(HALF / 2 - 1);          // mid scl low
    localparam logic [CNT_W-1:0] RISE = CNT_W'(HALF - 1);
    localparam logic [CNT_W-1:0] SMP  = CNT_W'(HALF + (HALF - 1) / 2);  // mid scl high
    localparam logic [CNT_W-1:0] LAST = CNT_W'(2 * HALF - 1);

    eeprom_phase_t          phase;
    eeprom_cmd_t            cmd_r;
    logic [CNT_W-1:0]       cnt;
    logic [3:0]             bit_cnt;
    logic [`EE_DATA_W-1:0]  shift;
    logic [EE_BANK_W-1:0]   bank;
    logic                   sda_smp;
    logic                   nack_flag;
    logic                   at_drv;
    logic                   at_smp;
    logic                   at_last;
    logic                   ack_slot;

    assign pop      = (phase == PH_IDLE) && !empty;
    assign at_drv   = (phase != PH_IDLE) && (cnt == DRV);
    assign at_smp   = (phase != PH_IDLE) && (cnt == SMP);
    assign at_last  = (phase != PH_IDLE) && (cnt == LAST);
    assign ack_slot = (bit_cnt == 4'd8);   // ninth slot of a byte
    assign bank     = cmd_r.addr[`EE_ADDR_W-1 -: EE_BANK_W];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase     <= PH_IDLE;
            cnt       <= '0;
            bit_cnt   <= '0;
            scl       <= 1'b1;
            sda_out   <= 1'b1;
            sda_oe    <= 1'b0;
            done      <= 1'b0;
            nack      <= 1'b0;
            nack_flag <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            nack <= 1'b0;
            if (phase == PH_IDLE)
            begin
                cnt <= '0;
                if (pop)
                begin
                    nack_flag <= 1'b0;
                    phase     <= PH_START;
                end
            end
            else
            begin
                cnt <= at_last ? '0 : cnt + 1'b1;
                if (cnt == RISE)
                    scl <= 1'b1;
                if (at_drv)
                begin
                    case (phase)
                        PH_CTRL_WR, PH_ADDR, PH_DATA_WR, PH_CTRL_RD:
                        begin
                            sda_oe  <= !ack_slot;   // let go for slave ack
                            sda_out <= shift[`EE_DATA_W-1];
                        end
                        PH_RSTART, PH_MNACK:
                        begin
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b1;
                        end
                        PH_STOP:
                        begin
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b0;
                        end
                        PH_DATA_RD:
                            sda_oe <= 1'b0;
                        default: ;
                    endcase
                end
                if (at_smp)
                begin
                    case (phase)
                        PH_START, PH_RSTART:
                        begin
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b0;   // falling sda, scl high
                        end
                        PH_STOP:
                        begin
                            sda_oe  <= 1'b0;   // pull-up gives the stop edge
                            sda_out <= 1'b1;
                        end
                        default: ;
                    endcase
                end
                if (at_last)
                begin
                    if (phase != PH_STOP)
                        scl <= 1'b0;
                    case (phase)
                        PH_START:
                        begin
                            bit_cnt <= '0;
                            phase   <= PH_CTRL_WR;
                        end
                        PH_CTRL_WR, PH_ADDR, PH_DATA_WR, PH_CTRL_RD:
                        begin
                            if (!ack_slot)
                                bit_cnt <= bit_cnt + 1'b1;
                            else
                            begin
                                bit_cnt <= '0;
                                if (sda_smp)
                                begin
                                    nack_flag <= 1'b1;   // no ack, abort to stop
                                    phase     <= PH_STOP;
                                end
                                else
                                begin
                                    case (phase)
                                        PH_CTRL_WR: phase <= PH_ADDR;
                                        PH_ADDR:    phase <= cmd_r.rd ? PH_RSTART : PH_DATA_WR;
                                        PH_CTRL_RD: phase <= PH_DATA_RD;
                                        default:    phase <= PH_STOP;
                                    endcase
                                end
                            end
                        end
                        PH_RSTART:
                            phase <= PH_CTRL_RD;
                        PH_DATA_RD:
                        begin
                            if (bit_cnt == 4'd7)
                            begin
                                bit_cnt <= '0;
                                phase   <= PH_MNACK;
                            end
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        end
                        PH_MNACK:
                            phase <= PH_STOP;
                        PH_STOP:
                        begin
                            done  <= 1'b1;
                            nack  <= nack_flag;
                            phase <= PH_IDLE;
                        end
                        default:
                            phase <= PH_IDLE;
                    endcase
                end
            end
        end
    end

    // shared shift register, msb first both ways
    always_ff @(posedge CLK)
    begin
        if (pop)
            cmd_r <= cmd_in;
        if (at_smp)
            sda_smp <= sda_in;
        if (at_last)
        begin
            case (phase)
                PH_START:
                    shift <= {`EE_DEV_CODE, bank, 1'b0};
                PH_RSTART:
                    shift <= {`EE_DEV_CODE, bank, 1'b1};
                PH_CTRL_WR, PH_ADDR, PH_DATA_WR, PH_CTRL_RD:
                begin
                    if (!ack_slot)
                        shift <= shift << 1;
                    else if (phase == PH_CTRL_WR)
                        shift <= cmd_r.addr[`EE_DATA_W-1:0];   // word address
                    else
                        shift <= cmd_r.data;
                end
                PH_DATA_RD:
                    shift <= {shift[`EE_DATA_W-2:0], sda_smp};
                PH_STOP:
                    rd_data <= shift;
                default: ;
            endcase
        end
    end

endmodule

/* logic/eeprom_ctrl_top.sv */
`timescale 1ns/10ps
`include "eeprom_settings.svh"

module eeprom_ctrl_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  WR,
    input  logic                  RD,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    input  logic                  sda_in,
    output logic                  busy,
    output logic                  idle,
    output logic                  done,
    output logic                  nack,
    output logic [`EE_DATA_W-1:0] rd_data,
    output logic                  scl,
    output logic                  sda_out,
    output logic                  sda_oe
);
    import eeprom_pkg::*;

    logic        push;
    logic        pop;
    logic        empty;
    eeprom_cmd_t cmd_push;
    eeprom_cmd_t cmd_head;

    eeprom_host_port i_host_port (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (WR),
        .rd    (RD),
        .addr  (addr),
        .wdata (wdata),
        .done  (done),
        .push  (push),
        .cmd   (cmd_push),
        .busy  (busy),
        .idle  (idle)
    );

    eeprom_cmd_fifo #(
        .DEPTH (`EE_CMD_DEPTH)
    ) i_cmd_fifo (
        .CLK   (CLK),
        .RESET (RESET),
        .push  (push),
        .din   (cmd_push),
        .pop   (pop),
        .dout  (cmd_head),
        .empty (empty)
    );

    eeprom_serial_engine i_serial_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .empty   (empty),
        .cmd_in  (cmd_head),
        .sda_in  (sda_in),
        .pop     (pop),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .done    (done),
        .nack    (nack),
        .rd_data (rd_data)
    );

endmodule

/* testbench/eeprom_slave_model.sv */
`timescale 1ns/10ps

module eeprom_slave_model (
    input  logic scl,
    input  logic sda,
    input  logic enable,
    output logic sda_low
);

    logic [7:0]  mem [2048];
    logic [7:0]  shift    = 8'h00;
    logic [7:0]  out_byte = 8'h00;
    logic [2:0]  bank     = 3'b000;
    logic [10:0] ptr      = 11'h000;
    logic        pull     = 1'b0;
    logic        scl_q    = 1'b0;
    logic        sda_q    = 1'b0;
    logic        active   = 1'b0;   // addressed since the last start
    logic        reading  = 1'b0;   // slave sends, master acks
    int          bit_cnt  = 0;
    int          byte_cnt = 0;

    assign sda_low = pull;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i * 7) ^ 8'(i >> 8);
    end

    // called at the scl fall that ends the eighth bit of a received byte
    task automatic answer_byte;
        if (byte_cnt == 0)
        begin
            if (enable && shift[7:4] == 4'b1010)
            begin
                bank = shift[3:1];
                pull = 1'b1;
                if (shift[0])
                begin
                    reading  = 1'b1;
                    ptr      = {shift[3:1], ptr[7:0]};
                    out_byte = mem[ptr];
                end
            end
            else
            begin
                active = 1'b0;   // no ack, line stays released
                pull   = 1'b0;
            end
        end
        else if (byte_cnt == 1)
        begin
            ptr  = {bank, shift};
            pull = 1'b1;
        end
        else
        begin
            mem[ptr] = shift;
            pull     = 1'b1;
        end
    endtask

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            active   = 1'b1;   // start or repeated start
            reading  = 1'b0;
            bit_cnt  = -1;     // next scl fall only ends the start
            byte_cnt = 0;
            pull     = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            active = 1'b0;     // stop
            pull   = 1'b0;
        end
        else if (active && scl_q === 1'b0 && scl === 1'b1)
        begin
            if (bit_cnt < 8 && !reading)
                shift = {shift[6:0], sda};
            else if (bit_cnt == 8 && reading && byte_cnt != 0 && sda === 1'b1)
                active = 1'b0;   // master nack ends the read
        end
        else if (active && scl_q === 1'b1 && scl === 1'b0)
        begin
            if (bit_cnt == 8)
            begin
                bit_cnt  = 0;
                byte_cnt = byte_cnt + 1;
                pull     = reading ? ~out_byte[7] : 1'b0;
            end
            else
            begin
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8 && reading)
                    pull = 1'b0;   // master owns its ack slot
                else if (bit_cnt == 8)
                    answer_byte();
                else if (reading)
                    pull = ~out_byte[7 - bit_cnt];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* testbench/eeprom_ctrl_assert.sv */
`timescale 1ns/10ps

module eeprom_ctrl_assert (
    input logic CLK,
    input logic RESET,
    input logic done,
    input logic nack,
    input logic busy,
    input logic idle,
    input logic scl,
    input logic sda_oe
);

    done_one_cycle: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("done stayed high for more than one cycle");

    nack_with_done: assert property (@(posedge CLK) disable iff (RESET) nack |-> done)
        else $error("nack high without done");

    busy_idle_apart: assert property (@(posedge CLK) disable iff (RESET) !(busy && idle))
        else $error("busy and idle high together");

    // bus must be released whenever nothing is pending
    idle_bus_free: assert property (@(posedge CLK) disable iff (RESET) idle |-> (scl && !sda_oe))
        else $error("bus not released while idle");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_assert i_assert (
    .CLK    (CLK),
    .RESET  (RESET),
    .done   (done),
    .nack   (nack),
    .busy   (busy),
    .idle   (idle),
    .scl    (scl),
    .sda_oe (sda_oe)
);

/* testbench/eeprom_ctrl_tb.sv */
`timescale 1ns/10ps
`include "eeprom_settings.svh"

module eeprom_ctrl_tb;

    localparam int CLK_PERIOD = 10;
    localparam int DEPTH      = `EE_CMD_DEPTH;
    localparam int NUM_CMDS   = 48;   // rounded up command count of all tests
    localparam int CMD_BITS   = 40;   // a read takes 39 scl periods
    localparam int TIMEOUT_NS = 2 * NUM_CMDS * CMD_BITS * 2 * `EE_SCL_HALF * CLK_PERIOD;

    typedef logic [`EE_ADDR_W-1:0] addr_t;
    typedef logic [`EE_DATA_W-1:0] data_t;

    typedef struct packed {
        logic  rd;
        logic  nack;
        addr_t addr;
        data_t data;
    } expect_t;

    logic   CLK;
    logic   RESET;
    logic   WR;
    logic   RD;
    addr_t  addr;
    data_t  wdata;
    logic   busy;
    logic   idle;
    logic   done;
    logic   nack;
    data_t  rd_data;
    logic   scl;
    logic   sda_out;
    logic   sda_oe;
    logic   sda_line;
    logic   slave_low;
    logic   slave_en;

    data_t   shadow [2048];
    expect_t in_flight [$];
    int      errors;
    integer  seed;

    // pull-up, master driver and slave pull-low on one wire
    assign sda_line = (sda_oe ? sda_out : 1'b1) & ~slave_low;

    eeprom_ctrl_top i_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .WR      (WR),
        .RD      (RD),
        .addr    (addr),
        .wdata   (wdata),
        .sda_in  (sda_line),
        .busy    (busy),
        .idle    (idle),
        .done    (done),
        .nack    (nack),
        .rd_data (rd_data),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

    eeprom_slave_model i_slave (
        .scl     (scl),
        .sda     (sda_line),
        .enable  (slave_en),
        .sda_low (slave_low)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic data_t fill_value(input int a);
        return 8'(a * 7) ^ 8'(a >> 8);   // power-up contents of the slave
    endfunction

    task automatic abort_run;
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic retire_command;
        expect_t exp;
        if (in_flight.size() == 0)
        begin
            $display("done pulse at %0t ns while no request was outstanding", $time);
            abort_run();
        end
        else
        begin
            exp = in_flight.pop_front();
            check(32'(nack), 32'(exp.nack), $sformatf("nack of %s at %0h",
                  exp.rd ? "read" : "write", exp.addr));
            if (exp.rd && !exp.nack)
                check(32'(rd_data), 32'(exp.data), $sformatf("read data at %0h", exp.addr));
        end
    endtask

    // every wait goes through here so no done pulse is missed
    task automatic next_cycle;
        @(posedge CLK);
        #1;
        if (done)
            retire_command();
    endtask

    task automatic issue(input logic is_rd, input addr_t a, input data_t d, input logic exp_nack);
        expect_t exp;
        while (busy)
            next_cycle();
        exp.rd   = is_rd;
        exp.nack = exp_nack;
        exp.addr = a;
        exp.data = is_rd ? shadow[a] : d;
        if (!is_rd && !exp_nack)
            shadow[a] = d;
        in_flight.push_back(exp);
        WR    = !is_rd;
        RD    = is_rd;
        addr  = a;
        wdata = d;
        next_cycle();
        WR    = 1'b0;
        RD    = 1'b0;
    endtask

    task automatic wait_all_done;
        while (in_flight.size() != 0)
            next_cycle();
        next_cycle();   // idle follows done by a cycle
        check(32'(idle), 1, "idle after last done");
        check(32'(busy), 0, "busy after last done");
    endtask

    task automatic test_reset_state;
        check(32'(idle), 1, "idle after reset");
        check(32'(busy), 0, "busy after reset");
        check(32'(done), 0, "done after reset");
        check(32'(scl), 1, "scl after reset");
        check(32'(sda_oe), 0, "sda_oe after reset");
    endtask

    task automatic test_write_read_back;
        issue(1'b0, 11'h123, 8'hA5, 1'b0);
        issue(1'b1, 11'h123, 8'h00, 1'b0);
        wait_all_done();
    endtask

    task automatic test_upper_address_bits;
        for (int b = 0; b < 8; b++)
            issue(1'b0, {3'(b), 8'h5A}, data_t'(8'h30 + b * 17), 1'b0);
        for (int b = 0; b < 8; b++)
            issue(1'b1, {3'(b), 8'h5A}, 8'h00, 1'b0);
        wait_all_done();
    endtask

    task automatic test_queued_requests;
        for (int i = 0; i < DEPTH; i++)
        begin
            issue(1'b0, addr_t'(16'h200 + i * 3), data_t'(8'h90 + i), 1'b0);
            check(32'(busy), (i == DEPTH - 1) ? 1 : 0, "busy while filling the queue");
        end
        WR    = 1'b1;   // dropped while busy is high
        addr  = 11'h200;
        wdata = 8'hFF;
        next_cycle();
        WR    = 1'b0;
        for (int i = 0; i < DEPTH; i++)
            issue(1'b1, addr_t'(16'h200 + i * 3), 8'h00, 1'b0);
        wait_all_done();
    endtask

    task automatic test_not_acknowledge;
        slave_en = 1'b0;
        issue(1'b0, 11'h321, ~shadow[11'h321], 1'b1);
        wait_all_done();
        slave_en = 1'b1;
        issue(1'b1, 11'h321, 8'h00, 1'b0);
        wait_all_done();
    endtask

    task automatic test_random_traffic;
        logic [31:0] r;
        logic        is_rd;
        addr_t       a;
        data_t       d;
        for (int i = 0; i < 16; i++)
        begin
            r     = $random(seed);
            is_rd = r[0];
            r     = $random(seed);
            a     = {r[10:8], 5'b00000, r[2:0]};   // small pool so reads hit writes
            r     = $random(seed);
            d     = r[7:0];
            issue(is_rd, a, d, 1'b0);
        end
        wait_all_done();
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: tests still running after %0d ns", TIMEOUT_NS);
        abort_run();
    end

    initial
    begin
        CLK        = 1'b0;
        RESET      = 1'b1;
        WR         = 1'b0;
        RD         = 1'b0;
        addr       = '0;
        wdata      = '0;
        slave_en   = 1'b1;
        errors     = 0;
        seed       = 35734;
        for (int i = 0; i < 2048; i++)
            shadow[i] = fill_value(i);
        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;
        test_reset_state();
        test_write_read_back();
        test_upper_address_bits();
        test_queued_requests();
        test_not_acknowledge();
        test_random_traffic();
        if (errors == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            $display("TESTBENCH FAILED");
            $fatal(1, "errors found");
        end
    end

endmodule

/* sim.f */
+incdir+logic
logic/eeprom_pkg.sv
logic/eeprom_host_port.sv
logic/eeprom_cmd_fifo.sv
logic/eeprom_serial_engine.sv
logic/eeprom_ctrl_top.sv
testbench/eeprom_slave_model.sv
testbench/eeprom_ctrl_assert.sv
testbench/eeprom_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the eeprom controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=eeprom_ctrl_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module "$TOP" \
    --Mdir "$OBJ_DIR" \
    -o "$TOP" \
    -f sim.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail, see $LOG"
    exit 1
fi
